//--- Bender.yml
package:
  name: gps_tx

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - gps_pkg.sv
      - gps_chip_if.sv
      - ca_code_gen.sv
      - p_code_gen.sv
      - code_capture.sv
      - py_cipher.sv
      - gps_tx.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clk_gen.sv
      - tb_gps_tx.sv

//--- ca_code_gen.sv
// C/A Gold-code generator with G1/G2 registers and satellite phase selection
`timescale 1ns/1ps
`include "gps_config.svh"

module ca_code_gen import gps_pkg::*; (
   input  logic    gps_clk_fast,
   input  logic    rst_n,
   input  sv_num_t sv_num,
   gps_chip_if.gen chips
);

   localparam int DIV_W = (`GPS_CA_DIV > 1) ? $clog2(`GPS_CA_DIV) : 1;

   logic [DIV_W-1:0] div_cnt;
   logic             active;
   sv_num_t          sv_q;
   logic [10:1]      g1;
   logic [10:1]      g2;
   tap_pair_t        taps;

   // PRN is frozen for the whole round
   assign taps = CA_TAPS[prn_index(sv_q)];

   // Output chip comes from the registers before they step
   assign chips.ca_chip = g1[10] ^ g2[taps.tap_a] ^ g2[taps.tap_b];

   always_ff @(posedge gps_clk_fast or negedge rst_n) begin
      if (!rst_n) begin
         div_cnt         <= '0;
         active          <= 1'b0;
         sv_q            <= '0;
         chips.ca_strobe <= 1'b0;
         g1              <= '1;
         g2              <= '1;
      end else if (chips.round_start) begin
         div_cnt         <= '0;
         active          <= 1'b1;
         sv_q            <= sv_num;
         chips.ca_strobe <= 1'b0;
         g1              <= '1;
         g2              <= '1;
      end else begin
         // Both registers advance once per chip strobe
         if (chips.ca_strobe) begin
            g1 <= {g1[9:1], g1[3] ^ g1[10]};
            g2 <= {g2[9:1], g2[2] ^ g2[3] ^ g2[6] ^ g2[8] ^ g2[9] ^ g2[10]};
         end
         // Chip-rate divider
         if (active) begin
            if (div_cnt == DIV_W'(`GPS_CA_DIV - 1)) begin
               div_cnt         <= '0;
               chips.ca_strobe <= 1'b1;
            end else begin
               div_cnt         <= div_cnt + 1'b1;
               chips.ca_strobe <= 1'b0;
            end
         end
      end
   end

endmodule

//--- code_capture.sv
// Chip capture shift register with a parameterized payload type and done pulse
`timescale 1ns/1ps
`include "gps_config.svh"

module code_capture import gps_pkg::*; #(
   parameter int  LEN    = `GPS_P_LEN,
   parameter type word_t = p_block_t
) (
   input  logic    gps_clk_fast,
   input  logic    rst_n,
   gps_chip_if.cap chips,
   input  logic    sel_p,
   output word_t   word,
   output logic    done
);

   localparam int CNT_W = $clog2(LEN + 1);

   logic [LEN-1:0]   sreg;
   logic [CNT_W-1:0] cnt;
   logic             strobe;
   logic             chip;

   // Role of the instance picks the chip pair
   assign strobe = sel_p ? chips.p_strobe : chips.ca_strobe;
   assign chip   = sel_p ? chips.p_chip   : chips.ca_chip;

   assign word = word_t'(sreg);

   always_ff @(posedge gps_clk_fast or negedge rst_n) begin
      if (!rst_n) begin
         sreg <= '0;
         cnt  <= '0;
         done <= 1'b0;
      end else begin
         done <= 1'b0;
         if (chips.round_start) begin
            sreg <= '0;
            cnt  <= '0;
         end else if (strobe && cnt != CNT_W'(LEN)) begin
            // Newest chip lands in bit 0
            sreg <= {sreg[LEN-2:0], chip};
            cnt  <= cnt + 1'b1;
            done <= (cnt == CNT_W'(LEN - 1));
         end
      end
   end

endmodule

//--- filelist.f
+incdir+.
gps_pkg.sv
gps_chip_if.sv
ca_code_gen.sv
p_code_gen.sv
code_capture.sv
py_cipher.sv
gps_tx.sv
tb_clk_gen.sv
tb_gps_tx.sv

//--- gps_chip_if.sv
// Chip stream bundle between the code generators and the capture stages
`timescale 1ns/1ps

interface gps_chip_if;

   // Restart pulse from the top
   logic round_start;

   // Slow C/A chips that are valid while ca_strobe is high
   logic ca_strobe;
   logic ca_chip;

   // P chips at one per cycle once a round is running
   logic p_strobe;
   logic p_chip;

   modport gen (
      input  round_start,
      output ca_strobe,
      output ca_chip,
      output p_strobe,
      output p_chip
   );

   modport cap (
      input round_start,
      input ca_strobe,
      input ca_chip,
      input p_strobe,
      input p_chip
   );

endinterface

//--- gps_config.svh
// Build-time constants for the GPS spreading-code transmitter
`ifndef GPS_CONFIG_SVH
`define GPS_CONFIG_SVH

// Fast clock cycles per C/A chip
`define GPS_CA_DIV 10

// Chips captured per round
`define GPS_CA_LEN 13
`define GPS_P_LEN 128

// Iterations of the Y-code block cipher
`define GPS_PY_ROUNDS 4

// Cipher key as four 32-bit words with the most significant word first
`define GPS_PY_KEY 128'h3C6E_F372_A54F_F53A_510E_527F_9B05_688C

`endif

//--- gps_pkg.sv
// Shared word types, C/A phase-selector tap table and PRN mapping function
`include "gps_config.svh"

package gps_pkg;

   typedef logic [5:0]                       sv_num_t;
   typedef logic [`GPS_CA_LEN-1:0]           ca_word_t;
   typedef logic [`GPS_P_LEN/32-1:0][31:0]   p_block_t;

   typedef logic [3:0] tap_t;

   // G2 stage numbers XORed together for one PRN
   typedef struct packed {
      tap_t tap_a;
      tap_t tap_b;
   } tap_pair_t;

   // Standard phase-selector assignment where entry n serves PRN n
   localparam tap_pair_t CA_TAPS [1:32] = '{
      '{4'd2, 4'd6}, '{4'd3, 4'd7}, '{4'd4, 4'd8},  '{4'd5, 4'd9},
      '{4'd1, 4'd9}, '{4'd2, 4'd10}, '{4'd1, 4'd8}, '{4'd2, 4'd9},
      '{4'd3, 4'd10}, '{4'd2, 4'd3}, '{4'd3, 4'd4}, '{4'd5, 4'd6},
      '{4'd6, 4'd7}, '{4'd7, 4'd8}, '{4'd8, 4'd9},  '{4'd9, 4'd10},
      '{4'd1, 4'd4}, '{4'd2, 4'd5}, '{4'd3, 4'd6},  '{4'd4, 4'd7},
      '{4'd5, 4'd8}, '{4'd6, 4'd9}, '{4'd1, 4'd3},  '{4'd4, 4'd6},
      '{4'd5, 4'd7}, '{4'd6, 4'd8}, '{4'd7, 4'd9},  '{4'd8, 4'd10},
      '{4'd1, 4'd6}, '{4'd2, 4'd7}, '{4'd3, 4'd8},  '{4'd4, 4'd9}
   };

   // Out-of-range satellite numbers fall back to PRN 1
   function automatic logic [5:0] prn_index(input sv_num_t sv);
      if (sv >= 6'd1 && sv <= 6'd32) begin
         return sv;
      end
      return 6'd1;
   endfunction

endpackage

//--- gps_tx.sv
// Top level of the GPS spreading-code transmitter
`timescale 1ns/1ps
`include "gps_config.svh"

module gps_tx import gps_pkg::*; (
   input  logic                   gps_clk_fast,
   input  logic                   rst_n,
   input  logic [5:0]             sv_num,
   input  logic                   start_round,
   output logic [`GPS_CA_LEN-1:0] ca_code,
   output logic [`GPS_P_LEN-1:0]  p_code,
   output logic [`GPS_P_LEN-1:0]  py_code,
   output logic                   py_code_valid
);

   logic round_start;
   logic p_done;
   logic cipher_load;

   gps_chip_if chips ();

   // One register stage between the request and the generators
   always_ff @(posedge gps_clk_fast or negedge rst_n) begin
      if (!rst_n) begin
         round_start <= 1'b0;
      end else begin
         round_start <= start_round;
      end
   end

   assign chips.round_start = round_start;

   // No cipher load in a restart cycle
   assign cipher_load = p_done & ~round_start;

   ca_code_gen u_ca_gen (
      .gps_clk_fast (gps_clk_fast),
      .rst_n        (rst_n),
      .sv_num       (sv_num),
      .chips        (chips)
   );

   p_code_gen u_p_gen (
      .gps_clk_fast (gps_clk_fast),
      .rst_n        (rst_n),
      .sv_num       (sv_num),
      .chips        (chips)
   );

   code_capture #(
      .LEN    (`GPS_CA_LEN),
      .word_t (ca_word_t)
   ) u_ca_cap (
      .gps_clk_fast (gps_clk_fast),
      .rst_n        (rst_n),
      .chips        (chips),
      .sel_p        (1'b0),
      .word         (ca_code),
      .done         ()
   );

   code_capture #(
      .LEN    (`GPS_P_LEN),
      .word_t (p_block_t)
   ) u_p_cap (
      .gps_clk_fast (gps_clk_fast),
      .rst_n        (rst_n),
      .chips        (chips),
      .sel_p        (1'b1),
      .word         (p_code),
      .done         (p_done)
   );

   py_cipher u_cipher (
      .gps_clk_fast (gps_clk_fast),
      .rst_n        (rst_n),
      .load         (cipher_load),
      .block_in     (p_code),
      .block_out    (py_code),
      .valid        (py_code_valid)
   );

endmodule

//--- p_code_gen.sv
// P-like chip generator built from two 12-bit Fibonacci LFSRs
`timescale 1ns/1ps

module p_code_gen import gps_pkg::*; (
   input  logic    gps_clk_fast,
   input  logic    rst_n,
   input  sv_num_t sv_num,
   gps_chip_if.gen chips
);

   logic [11:0] x1;
   logic [11:0] x2;
   logic        x1_fb;
   logic        x2_fb;
   logic [11:0] x2_seed;

   // x1 taps 12, 11, 8, 6
   assign x1_fb = x1[11] ^ x1[10] ^ x1[7] ^ x1[5];

   // x2 taps 12, 11, 10, 9, 8, 7, 5, 3, 2, 1
   assign x2_fb = x2[11] ^ x2[10] ^ x2[9] ^ x2[8] ^ x2[7] ^ x2[6]
                ^ x2[4] ^ x2[2] ^ x2[1] ^ x2[0];

   // Satellite number perturbs the low bits of the x2 seed
   assign x2_seed = 12'hFFF ^ {6'b0, sv_num};

   assign chips.p_chip = x1[11] ^ x2[11];

   always_ff @(posedge gps_clk_fast or negedge rst_n) begin
      if (!rst_n) begin
         chips.p_strobe <= 1'b0;
         x1             <= '1;
         x2             <= '1;
      end else if (chips.round_start) begin
         chips.p_strobe <= 1'b1;
         x1             <= '1;
         x2             <= x2_seed;
      end else if (chips.p_strobe) begin
         // Feedback enters at bit 0
         x1 <= {x1[10:0], x1_fb};
         x2 <= {x2[10:0], x2_fb};
      end
   end

endmodule

//--- py_cipher.sv
// Iterative keyed rotate-and-XOR block cipher producing the Y-code block
`timescale 1ns/1ps
`include "gps_config.svh"

module py_cipher import gps_pkg::*; (
   input  logic     gps_clk_fast,
   input  logic     rst_n,
   input  logic     load,
   input  p_block_t block_in,
   output p_block_t block_out,
   output logic     valid
);

   localparam int             W      = $bits(p_block_t);
   localparam int             ROUNDS = `GPS_PY_ROUNDS;
   localparam int             RND_W  = (ROUNDS > 1) ? $clog2(ROUNDS) : 1;
   localparam logic [W-1:0]   KEY    = `GPS_PY_KEY;

   logic [W-1:0]     state;
   logic [W-1:0]     round_out;
   logic [RND_W-1:0] rnd;
   logic             busy;

   function automatic logic [W-1:0] rotl(input logic [W-1:0] x, input int unsigned n);
      return (x << n) | (x >> (W - n));
   endfunction

   // Round key is the key rotated by one word per round
   assign round_out = rotl(state, 13) ^ rotl(KEY, 32 * rnd);

   // Working block
   always_ff @(posedge gps_clk_fast) begin
      if (load) begin
         state <= block_in;
      end else if (busy) begin
         state <= round_out;
      end
   end

   always_ff @(posedge gps_clk_fast or negedge rst_n) begin
      if (!rst_n) begin
         busy      <= 1'b0;
         rnd       <= '0;
         valid     <= 1'b0;
         block_out <= '0;
      end else begin
         valid <= 1'b0;
         if (load) begin
            // A fresh block drops whatever was in flight
            busy <= 1'b1;
            rnd  <= '0;
         end else if (busy) begin
            rnd <= rnd + 1'b1;
            if (rnd == RND_W'(ROUNDS - 1)) begin
               busy      <= 1'b0;
               block_out <= round_out;
               valid     <= 1'b1;
            end
         end
      end
   end

endmodule

//--- tb_clk_gen.sv
// Testbench clock and power-on reset generator
`timescale 1ns/1ps

module tb_clk_gen #(
   parameter int PERIOD_NS    = 40,
   parameter int RESET_CYCLES = 5
) (
   output logic gps_clk_fast,
   output logic rst_n
);

   initial begin
      gps_clk_fast = 1'b0;
      forever #(PERIOD_NS / 2) gps_clk_fast = ~gps_clk_fast;
   end

   // Reset held low for a fixed number of rising edges
   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge gps_clk_fast);
      rst_n <= 1'b1;
   end

endmodule

//--- tb_gps_tx.sv
// Testbench for gps_tx with reference models, stimulus, checker and timeouts
`timescale 1ns/1ps
`include "gps_config.svh"

module tb_gps_tx import gps_pkg::*; ();

   localparam int                     TIMEOUT_CYCLES = 200;
   // Tap masks for x1 taps 12 11 8 6 and x2 taps 12 11 10 9 8 7 5 3 2 1
   localparam logic [11:0]            X1_TAPS = 12'hCA0;
   localparam logic [11:0]            X2_TAPS = 12'hFD7;
   localparam logic [`GPS_P_LEN-1:0]  KEY     = `GPS_PY_KEY;

   logic                   gps_clk_fast;
   logic                   rst_n;
   logic [5:0]             sv_num;
   logic                   start_round;
   logic [`GPS_CA_LEN-1:0] ca_code;
   logic [`GPS_P_LEN-1:0]  p_code;
   logic [`GPS_P_LEN-1:0]  py_code;
   logic                   py_code_valid;

   logic [`GPS_CA_LEN-1:0] exp_ca_q[$];
   logic [`GPS_P_LEN-1:0]  exp_p_q[$];
   logic [`GPS_P_LEN-1:0]  exp_py_q[$];
   int                     rounds_expected = 0;
   int                     rounds_checked  = 0;
   logic [31:0]            lfsr_state      = 32'd67784;

   tb_clk_gen #(.PERIOD_NS(40), .RESET_CYCLES(5)) u_clk_gen (
      .gps_clk_fast (gps_clk_fast),
      .rst_n        (rst_n)
   );

   gps_tx u_dut (
      .gps_clk_fast  (gps_clk_fast),
      .rst_n         (rst_n),
      .sv_num        (sv_num),
      .start_round   (start_round),
      .ca_code       (ca_code),
      .p_code        (p_code),
      .py_code       (py_code),
      .py_code_valid (py_code_valid)
   );

   // Right-shifting Galois LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic lsb;
      lsb = s[0];
      s   = s >> 1;
      if (lsb) begin
         s = s ^ 32'h8020_0003;
      end
      return s;
   endfunction

   function automatic int prn_of(input logic [5:0] sv);
      if (sv >= 6'd1 && sv <= 6'd32) begin
         return int'(sv);
      end
      return 1;
   endfunction

   function automatic logic [`GPS_CA_LEN-1:0] ref_ca(input int prn);
      logic [10:1]            g1;
      logic [10:1]            g2;
      logic [`GPS_CA_LEN-1:0] code;
      tap_pair_t              tp;
      g1   = '1;
      g2   = '1;
      code = '0;
      tp   = CA_TAPS[prn];
      for (int i = 0; i < `GPS_CA_LEN; i++) begin
         code = {code[`GPS_CA_LEN-2:0], g1[10] ^ g2[tp.tap_a] ^ g2[tp.tap_b]};
         g1   = {g1[9:1], g1[3] ^ g1[10]};
         g2   = {g2[9:1], g2[2] ^ g2[3] ^ g2[6] ^ g2[8] ^ g2[9] ^ g2[10]};
      end
      return code;
   endfunction

   function automatic logic [`GPS_P_LEN-1:0] ref_p(input logic [5:0] sv);
      logic [11:0]           x1;
      logic [11:0]           x2;
      logic [`GPS_P_LEN-1:0] blk;
      x1  = 12'hFFF;
      x2  = 12'hFFF ^ {6'b0, sv};
      blk = '0;
      for (int i = 0; i < `GPS_P_LEN; i++) begin
         blk = {blk[`GPS_P_LEN-2:0], x1[11] ^ x2[11]};
         x1  = {x1[10:0], ^(x1 & X1_TAPS)};
         x2  = {x2[10:0], ^(x2 & X2_TAPS)};
      end
      return blk;
   endfunction

   function automatic logic [`GPS_P_LEN-1:0] rotl(input logic [`GPS_P_LEN-1:0] x, input int n);
      logic [2*`GPS_P_LEN-1:0] both;
      both = {x, x} << n;
      return both[2*`GPS_P_LEN-1:`GPS_P_LEN];
   endfunction

   function automatic logic [`GPS_P_LEN-1:0] ref_py(input logic [`GPS_P_LEN-1:0] blk);
      logic [`GPS_P_LEN-1:0] state;
      state = blk;
      for (int i = 0; i < `GPS_PY_ROUNDS; i++) begin
         state = rotl(state, 13) ^ rotl(KEY, 32 * i);
      end
      return state;
   endfunction

   task automatic report_failure(input string what);
      $display("ERROR at %0t ns: %s", $time, what);
      $display("Simulation failed");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic report_mismatch(input string name, input logic [127:0] got,
                                  input logic [127:0] exp);
      $display("FAIL at %0t ns: %s got %h expected %h", $time, name, got, exp);
      $display("Simulation failed");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic check_value(input string name, input logic [127:0] got,
                              input logic [127:0] exp);
      assert (got === exp) else report_mismatch(name, got, exp);
   endtask

   // One random bit per LFSR step
   task automatic draw_sv(output logic [5:0] sv);
      sv = '0;
      for (int i = 0; i < 6; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         sv = {sv[4:0], lfsr_state[0]};
      end
   endtask

   task automatic wait_reset_release();
      int cycles;
      cycles = 0;
      while (!rst_n && cycles < TIMEOUT_CYCLES) begin
         @(posedge gps_clk_fast);
         cycles++;
      end
      if (!rst_n) begin
         report_failure("reset was never released");
      end
   endtask

   task automatic check_idle_outputs();
      repeat (20) begin
         @(negedge gps_clk_fast);
         check_value("py_code_valid", py_code_valid, 1'b0);
         check_value("ca_code", ca_code, '0);
         check_value("p_code", p_code, '0);
         check_value("py_code", py_code, '0);
      end
   endtask

   task automatic launch_round(input logic [5:0] sv);
      @(posedge gps_clk_fast);
      sv_num      <= sv;
      start_round <= 1'b1;
      @(posedge gps_clk_fast);
      start_round <= 1'b0;
   endtask

   task automatic expect_round(input logic [5:0] sv);
      logic [`GPS_P_LEN-1:0] blk;
      blk = ref_p(sv);
      exp_ca_q.push_back(ref_ca(prn_of(sv)));
      exp_p_q.push_back(blk);
      exp_py_q.push_back(ref_py(blk));
      rounds_expected++;
   endtask

   task automatic wait_for_checks();
      int cycles;
      cycles = 0;
      while (rounds_checked < rounds_expected && cycles < TIMEOUT_CYCLES) begin
         @(posedge gps_clk_fast);
         cycles++;
      end
      if (rounds_checked < rounds_expected) begin
         report_failure("no py_code_valid pulse within the timeout");
      end
   endtask

   task automatic run_round(input logic [5:0] sv);
      expect_round(sv);
      launch_round(sv);
      wait_for_checks();
   endtask

   // Old round is dropped during capture so only the new one may complete
   task automatic run_restarted_round(input logic [5:0] sv_old, input logic [5:0] sv_new);
      launch_round(sv_old);
      repeat (60) @(posedge gps_clk_fast);
      expect_round(sv_new);
      launch_round(sv_new);
      wait_for_checks();
   endtask

   // Compares every valid pulse against the oldest expected round
   initial begin : compare_proc
      forever begin
         @(negedge gps_clk_fast);
         if (rst_n && py_code_valid) begin
            if (exp_p_q.size() == 0) begin
               report_failure("py_code_valid pulsed with no round pending");
            end else begin
               check_value("ca_code", ca_code, exp_ca_q.pop_front());
               check_value("p_code", p_code, exp_p_q.pop_front());
               check_value("py_code", py_code, exp_py_q.pop_front());
               @(negedge gps_clk_fast);
               check_value("py_code_valid", py_code_valid, 1'b0);
               rounds_checked++;
            end
         end
      end
   end

   initial begin : stimulus_proc
      logic [5:0]             sv;
      logic [`GPS_CA_LEN-1:0] ca_prn1;
      sv_num      = '0;
      start_round = 1'b0;
      wait_reset_release();
      // Published first ten chips of PRN 1 are octal 1440
      ca_prn1 = ref_ca(1);
      assert (ca_prn1[`GPS_CA_LEN-1 -: 10] == 10'b1100100000)
         else report_failure("C/A reference model disagrees with the PRN 1 prefix");
      check_idle_outputs();
      run_round(6'd1);
      run_round(6'd7);
      run_round(6'd32);
      run_round(6'd0);
      run_round(6'd45);
      for (int n = 0; n < 4; n++) begin
         draw_sv(sv);
         run_round(sv);
      end
      run_restarted_round(6'd3, 6'd19);
      repeat (10) @(posedge gps_clk_fast);
      if (rounds_checked == rounds_expected && exp_p_q.size() == 0) begin
         $display("Simulation completed successfully");
         $finish;
      end else begin
         report_failure("rounds left unchecked at the end of the run");
      end
   end

endmodule
